//--- rtl/laa_macros.svh
`ifndef LAA_MACROS_SVH
`define LAA_MACROS_SVH

// Element width in bits
`define LAA_WIDTH 32

// Matrix is LAA_DIM x LAA_DIM
`define LAA_DIM 3
`define LAA_ELEMS 9

// Bit 4 picks A or B and the low bits give the element index
`define LAA_ADDR_W 5

// All-ones address starts a multiply
`define LAA_MULT_ADDR {`LAA_ADDR_W{1'b1}}

`endif

//--- rtl/laa_data_pkg.sv
`include "laa_macros.svh"

package laa_data_pkg;

    typedef logic [`LAA_WIDTH-1:0] element_t;

    typedef element_t [`LAA_ELEMS-1:0] matrix_t; // Row-major order by row*3 + col

    typedef logic [3:0] index_t;

    typedef logic [1:0] coord_t; // Row, column or k

    // One multiply-accumulate step
    typedef struct packed {
        coord_t row;
        coord_t col;
        coord_t k;
        logic   first;  // k == 0
        logic   last_k; // k == 2
    } mac_pos_t;

    typedef struct packed {
        logic     en;
        index_t   index;
        element_t value;
    } c_write_t;

    function automatic index_t elem_index(coord_t r, coord_t c);
        return index_t'(r) * index_t'(`LAA_DIM) + index_t'(c);
    endfunction

endpackage

//--- rtl/laa_ctrl_pkg.sv
package laa_ctrl_pkg;

    // What an access means once decoded
    typedef enum logic [2:0] {
        OP_NONE,
        OP_WRITE_A,
        OP_WRITE_B,
        OP_READ_ONLY,
        OP_MULTIPLY
    } op_e;

    typedef enum logic [1:0] {
        S_IDLE,
        S_MAC,
        S_COMMIT
    } seq_state_e;

    // Decoded address, shared by the read and write ports
    typedef struct packed {
        op_e                   op;
        logic                  matrix_b;
        laa_data_pkg::index_t  index;
        logic                  valid;    // Address maps to an element
    } access_t;

endpackage

//--- rtl/matrix_regfile.sv
module matrix_regfile (
    input  logic                    clk,
    input  logic                    reset,
    input  laa_ctrl_pkg::access_t   access,
    input  logic                    wr_en,
    input  laa_data_pkg::element_t  data_in,
    input  laa_data_pkg::mac_pos_t  pos,
    input  laa_data_pkg::c_write_t  c_wr,
    input  logic                    commit,
    output laa_data_pkg::element_t  data_out,
    output laa_data_pkg::element_t  a_operand,
    output laa_data_pkg::element_t  b_operand
);

    laa_data_pkg::matrix_t a_q;
    laa_data_pkg::matrix_t b_q;
    laa_data_pkg::matrix_t c_q;
    laa_data_pkg::matrix_t c_next;

    // C with this cycle's write folded in
    always_comb begin
        c_next = c_q;
        if (c_wr.en) begin
            c_next[c_wr.index] = c_wr.value;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            a_q <= '0;
            b_q <= '0;
        end else if (commit) begin
            a_q <= c_next; // Last C element arrives with commit
        end else if (wr_en) begin
            if (access.op == laa_ctrl_pkg::OP_WRITE_B) begin
                b_q[access.index] <= data_in;
            end else begin
                a_q[access.index] <= data_in;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            c_q <= '0;
        end else if (c_wr.en) begin
            c_q <= c_next;
        end
    end

    // Read port
    always_comb begin
        data_out = '0;
        if (access.valid) begin
            if (access.matrix_b) begin
                data_out = b_q[access.index];
            end else begin
                data_out = a_q[access.index];
            end
        end
    end

    // A walks row i along k, B walks column j along k
    assign a_operand = a_q[laa_data_pkg::elem_index(pos.row, pos.k)];
    assign b_operand = b_q[laa_data_pkg::elem_index(pos.k, pos.col)];

endmodule

//--- rtl/element_counter.sv
`include "laa_macros.svh"

module element_counter (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    count_clear,
    input  logic                    count_step,
    output laa_data_pkg::mac_pos_t  pos,
    output logic                    pos_last
);

    localparam laa_data_pkg::coord_t MAX_COORD = laa_data_pkg::coord_t'(`LAA_DIM - 1);

    laa_data_pkg::coord_t row_q;
    laa_data_pkg::coord_t col_q;
    laa_data_pkg::coord_t k_q;

    always_ff @(posedge clk) begin
        if (reset || count_clear) begin
            row_q <= '0;
            col_q <= '0;
            k_q   <= '0;
        end else if (count_step) begin
            if (k_q == MAX_COORD) begin
                k_q <= '0;
                if (col_q == MAX_COORD) begin
                    col_q <= '0;
                    row_q <= (row_q == MAX_COORD) ? '0 : row_q + 2'd1;
                end else begin
                    col_q <= col_q + 2'd1;
                end
            end else begin
                k_q <= k_q + 2'd1; // k runs fastest
            end
        end
    end

    assign pos.row    = row_q;
    assign pos.col    = col_q;
    assign pos.k      = k_q;
    assign pos.first  = (k_q == '0);
    assign pos.last_k = (k_q == MAX_COORD);

    assign pos_last = (row_q == MAX_COORD) && (col_q == MAX_COORD) && (k_q == MAX_COORD);

endmodule

//--- rtl/mac_datapath.sv
module mac_datapath (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    mac_en,
    input  laa_data_pkg::mac_pos_t  pos,
    input  laa_data_pkg::element_t  a_operand,
    input  laa_data_pkg::element_t  b_operand,
    output laa_data_pkg::c_write_t  c_wr
);

    laa_data_pkg::element_t product;
    laa_data_pkg::element_t sum;
    laa_data_pkg::element_t acc_q;
    logic                   c_en_q;
    laa_data_pkg::index_t   c_index_q;
    laa_data_pkg::element_t c_value_q;

    // Only the low 32 bits are kept
    assign product = a_operand * b_operand;
    assign sum     = pos.first ? product : acc_q + product;

    always_ff @(posedge clk) begin
        if (reset) begin
            c_en_q    <= 1'b0;
            acc_q     <= '0;
            c_index_q <= '0;
            c_value_q <= '0;
        end else begin
            c_en_q <= mac_en && pos.last_k; // One pulse per C element
            if (mac_en) begin
                acc_q <= sum;
                if (pos.last_k) begin
                    c_index_q <= laa_data_pkg::elem_index(pos.row, pos.col);
                    c_value_q <= sum;
                end
            end
        end
    end

    assign c_wr.en    = c_en_q;
    assign c_wr.index = c_index_q;
    assign c_wr.value = c_value_q;

endmodule

//--- rtl/mac_sequencer.sv
`include "laa_macros.svh"

module mac_sequencer (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         operate,
    input  logic [`LAA_ADDR_W-1:0]       addr,
    input  logic                         pos_last,
    output laa_ctrl_pkg::access_t        access,
    output logic                         wr_en,
    output logic                         count_clear,
    output logic                         count_step,
    output logic                         mac_en,
    output logic                         commit,
    output logic                         busy
);

    laa_ctrl_pkg::seq_state_e state_q;
    laa_ctrl_pkg::seq_state_e state_next;

    // Address decode
    always_comb begin
        access.op       = laa_ctrl_pkg::OP_NONE;
        access.matrix_b = addr[4];
        access.index    = laa_data_pkg::index_t'(addr[3:0]);
        access.valid    = 1'b0;
        if (addr == `LAA_MULT_ADDR) begin
            if (operate) begin
                access.op = laa_ctrl_pkg::OP_MULTIPLY;
            end
        end else if (addr[3:0] < `LAA_ELEMS) begin
            access.valid = 1'b1;
            if (!operate) begin
                access.op = laa_ctrl_pkg::OP_READ_ONLY;
            end else if (addr[4]) begin
                access.op = laa_ctrl_pkg::OP_WRITE_B;
            end else begin
                access.op = laa_ctrl_pkg::OP_WRITE_A;
            end
        end
    end

    always_comb begin
        state_next = state_q;
        case (state_q)
            laa_ctrl_pkg::S_IDLE: begin
                if (access.op == laa_ctrl_pkg::OP_MULTIPLY) begin
                    state_next = laa_ctrl_pkg::S_MAC;
                end
            end
            laa_ctrl_pkg::S_MAC: begin
                if (pos_last) begin
                    state_next = laa_ctrl_pkg::S_COMMIT; // 27th step done
                end
            end
            default: state_next = laa_ctrl_pkg::S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= laa_ctrl_pkg::S_IDLE;
        end else begin
            state_q <= state_next;
        end
    end

    // Strobes only count in idle
    assign wr_en = (state_q == laa_ctrl_pkg::S_IDLE) &&
                   (access.op == laa_ctrl_pkg::OP_WRITE_A ||
                    access.op == laa_ctrl_pkg::OP_WRITE_B);

    assign count_clear = (state_q == laa_ctrl_pkg::S_IDLE);
    assign count_step  = (state_q == laa_ctrl_pkg::S_MAC);
    assign mac_en      = (state_q == laa_ctrl_pkg::S_MAC);
    assign commit      = (state_q == laa_ctrl_pkg::S_COMMIT);
    assign busy        = (state_q != laa_ctrl_pkg::S_IDLE);

endmodule

//--- rtl/laa_top.sv
`include "laa_macros.svh"

module laa_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    operate,
    input  logic [`LAA_ADDR_W-1:0]  addr,
    input  laa_data_pkg::element_t  data_in,
    output laa_data_pkg::element_t  data_out,
    output logic                    busy
);

    laa_ctrl_pkg::access_t  access;
    logic                   wr_en;
    logic                   count_clear;
    logic                   count_step;
    logic                   mac_en;
    logic                   commit;
    laa_data_pkg::mac_pos_t pos;
    logic                   pos_last;
    laa_data_pkg::element_t a_operand;
    laa_data_pkg::element_t b_operand;
    laa_data_pkg::c_write_t c_wr;

    mac_sequencer u_sequencer (
        .clk         (clk),
        .reset       (reset),
        .operate     (operate),
        .addr        (addr),
        .pos_last    (pos_last),
        .access      (access),
        .wr_en       (wr_en),
        .count_clear (count_clear),
        .count_step  (count_step),
        .mac_en      (mac_en),
        .commit      (commit),
        .busy        (busy)
    );

    element_counter u_counter (
        .clk         (clk),
        .reset       (reset),
        .count_clear (count_clear),
        .count_step  (count_step),
        .pos         (pos),
        .pos_last    (pos_last)
    );

    mac_datapath u_mac (
        .clk       (clk),
        .reset     (reset),
        .mac_en    (mac_en),
        .pos       (pos),
        .a_operand (a_operand),
        .b_operand (b_operand),
        .c_wr      (c_wr)
    );

    matrix_regfile u_regfile (
        .clk       (clk),
        .reset     (reset),
        .access    (access),
        .wr_en     (wr_en),
        .data_in   (data_in),
        .pos       (pos),
        .c_wr      (c_wr),
        .commit    (commit),
        .data_out  (data_out),
        .a_operand (a_operand),
        .b_operand (b_operand)
    );

endmodule

//--- test/laa_sva.sv
`include "laa_macros.svh"

module laa_sva (
    input logic                    clk,
    input logic                    reset,
    input logic                    operate,
    input logic [`LAA_ADDR_W-1:0]  addr,
    input laa_data_pkg::element_t  data_out,
    input logic                    busy
);

    localparam int BUSY_CYCLES = `LAA_ELEMS * `LAA_DIM + 1; // MAC steps plus commit

    logic mult_strobe;
    logic unmapped;

    assign mult_strobe = operate && (addr == `LAA_MULT_ADDR) && !busy;
    assign unmapped    = (addr != `LAA_MULT_ADDR) && (addr[3:0] >= `LAA_ELEMS);

    busy_after_reset: assert property (@(posedge clk) reset |=> !busy)
        else $error("busy is high after a reset cycle");

    busy_rise: assert property (@(posedge clk) disable iff (reset) mult_strobe |=> busy)
        else $error("busy did not rise after a multiply strobe");

    // High for the full run and low the cycle before it
    busy_length: assert property (@(posedge clk) disable iff (reset)
        $fell(busy) |-> $past(busy, BUSY_CYCLES) && !$past(busy, BUSY_CYCLES + 1))
        else $error("busy was not high for exactly %0d cycles", BUSY_CYCLES);

    unmapped_zero: assert property (@(posedge clk) disable iff (reset)
        unmapped |-> data_out == '0)
        else $error("unmapped address %h reads %h", addr, data_out);

endmodule

bind laa_top laa_sva u_sva (
    .clk      (clk),
    .reset    (reset),
    .operate  (operate),
    .addr     (addr),
    .data_out (data_out),
    .busy     (busy)
);

//--- test/laa_tb.sv
`include "laa_macros.svh"

module laa_tb;

    localparam int BUSY_TIMEOUT = 200;
    localparam int BUSY_CYCLES  = `LAA_ELEMS * `LAA_DIM + 1; // 27 MAC steps and the commit

    logic                   clk;
    logic                   reset;
    logic                   operate;
    logic [`LAA_ADDR_W-1:0] addr;
    laa_data_pkg::element_t data_in;
    laa_data_pkg::element_t data_out;
    logic                   busy;

    int    errors;
    int    timeouts;
    int    fd;
    int    got;
    string line;

    laa_top DUT (
        .clk      (clk),
        .reset    (reset),
        .operate  (operate),
        .addr     (addr),
        .data_in  (data_in),
        .data_out (data_out),
        .busy     (busy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic drive(input logic op, input logic [`LAA_ADDR_W-1:0] a,
                         input laa_data_pkg::element_t d);
        @(posedge clk);
        operate <= op;
        addr    <= a;
        data_in <= d;
    endtask

    task automatic read_check(input logic [`LAA_ADDR_W-1:0] a,
                              input laa_data_pkg::element_t expected);
        drive(1'b0, a, '0);
        @(negedge clk); // data_out settled
        assert (data_out === expected) else begin
            errors++;
            $display("** Error at %0t: data_out at addr %h expected %h actual %h",
                     $time, a, expected, data_out);
        end
    endtask

    task automatic sweep_zero(input bit unmapped_only);
        logic [`LAA_ADDR_W-1:0] a;
        for (int i = 0; i < (1 << `LAA_ADDR_W) - 1; i++) begin
            a = i[`LAA_ADDR_W-1:0];
            if (!unmapped_only || a[3:0] >= `LAA_ELEMS) begin
                read_check(a, '0);
            end
        end
    endtask

    // Counts busy cycles at the falling edge
    task automatic wait_idle(input int expected_cycles);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (busy === 1'b1 && cycles < BUSY_TIMEOUT) begin
            cycles++;
            @(negedge clk);
        end
        if (busy !== 1'b0) begin
            timeouts++;
            $display("Timeout: busy still high %0d cycles into a multiply", cycles);
        end else begin
            assert (cycles == expected_cycles) else begin
                errors++;
                $display("** Error at %0t: busy cycles expected %0d actual %0d",
                         $time, expected_cycles, cycles);
            end
        end
    endtask

    task automatic run_line(input string text);
        byte                    cmd;
        int                     n;
        logic [`LAA_ADDR_W-1:0] t_addr;
        laa_data_pkg::element_t t_data;
        laa_data_pkg::element_t t_exp;
        cmd = text.getc(0);
        n   = $sscanf(text.substr(1, text.len() - 1), "%h %h %h", t_addr, t_data, t_exp);
        if (n != 3) begin
            errors++;
            $display("Trace line could not be parsed: %s", text);
        end else begin
            case (cmd)
                "W": begin
                    drive(1'b1, t_addr, t_data);
                    read_check(t_addr, t_exp);
                end
                "R": read_check(t_addr, t_exp);
                "M": begin
                    drive(1'b1, `LAA_MULT_ADDR, '0);
                    drive(1'b0, `LAA_MULT_ADDR, '0);
                    wait_idle(BUSY_CYCLES);
                end
                "X": begin
                    drive(1'b1, `LAA_MULT_ADDR, '0);
                    drive(1'b1, t_addr, t_data); // Lands one cycle into the run
                    drive(1'b0, t_addr, t_data);
                    wait_idle(BUSY_CYCLES - 1);
                    read_check(t_addr, t_exp);
                end
                default: begin
                    errors++;
                    $display("Unknown trace command in line: %s", text);
                end
            endcase
        end
    endtask

    initial begin
        errors   = 0;
        timeouts = 0;
        reset    = 1'b1;
        operate  = 1'b0;
        addr     = '0;
        data_in  = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        sweep_zero(1'b0);
        fd = $fopen("test/laa_trace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the trace file test/laa_trace.txt");
        end else begin
            while (!$feof(fd) && timeouts == 0) begin
                got = $fgets(line, fd);
                if (got > 1 && line.getc(0) != "#") begin
                    run_line(line);
                end
            end
            $fclose(fd);
            sweep_zero(1'b1);
        end
        $display("Errors: %0d  Timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+rtl
rtl/laa_data_pkg.sv
rtl/laa_ctrl_pkg.sv
rtl/matrix_regfile.sv
rtl/element_counter.sv
rtl/mac_datapath.sv
rtl/mac_sequencer.sv
rtl/laa_top.sv
test/laa_sva.sv
test/laa_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the laa testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f compile.f --top-module laa_tb \
    -Mdir obj_dir -o laa_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/laa_sim > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "Result: FAILED" "$log"; then
    echo "Testbench reported a failure, see $log"
    exit 1
fi

echo "Simulation finished without failures, see $log"
exit 0

//--- test/laa_trace.txt
# cmd addr data expect, all hex; W writes then reads back expect, R reads and compares
# M multiplies A by B; X multiplies and strobes a write while busy, then reads addr
W 00 00000001 00000001
W 01 00000002 00000002
W 02 00000003 00000003
W 03 00000004 00000004
W 04 00000005 00000005
W 05 00000006 00000006
W 06 00010000 00010000
W 07 80000000 80000000
W 08 00000007 00000007
W 10 00000002 00000002
W 11 00000000 00000000
W 12 00000001 00000001
W 13 00000003 00000003
W 14 00000001 00000001
W 15 00000000 00000000
W 16 00010000 00010000
W 17 00000004 00000004
W 18 ffffffff ffffffff
# unmapped writes read back zero
W 0c 12345678 00000000
W 1a 9abcdef0 00000000
M 1f 00000000 00000000
R 00 00000000 00030008
R 01 00000000 0000000e
R 02 00000000 fffffffe
R 03 00000000 00060017
R 04 00000000 0000001d
R 05 00000000 fffffffe
R 06 00000000 80090000
R 07 00000000 8000001c
R 08 00000000 0000fff9
R 16 00000000 00010000
# second product with B unchanged, the write to B[4] is dropped
X 14 0000dead 00000001
R 00 00000000 0004003a
R 01 00000000 00000006
R 02 00000000 0003000a
R 03 00000000 000a0085
R 04 00000000 00000015
R 05 00000000 00060019
R 06 00000000 800b0054
R 07 00000000 80040000
R 08 00000000 80080007
R 10 00000000 00000002
R 18 00000000 ffffffff
